//--- flist.f
rtl/dcache_pkg.sv
rtl/cache_array.sv
rtl/line_refill.sv
rtl/cache_controller.sv
rtl/dcache_top.sv
tb/mem_model.sv
tb/dcache_sva.sv
tb/tb_dcache.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the data cache testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f flist.f --top-module tb_dcache

status=0
./obj_dir/Vtb_dcache > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -ne 0 ] || grep -q "Verification failed" sim.log; then
    echo "Simulation reported errors, see sim.log"
    exit 1
fi
exit 0

//--- tb/tb_dcache.sv
`timescale 1ns/1ps
`default_nettype none

module tb_dcache;

    import dcache_pkg::*;

    localparam int NUM_LINES  = 32;
    localparam int IDX_W      = $clog2(NUM_LINES);
    localparam int LINE_SHIFT = WORD_OFF_W + BYTE_OFF_W;
    localparam int TIMEOUT    = 200;  // Cycles allowed per request

    logic              clk;
    logic              reset;
    cpu_req_t          cpu_req;
    logic [DATA_W-1:0] cpu_rdata;
    logic              cpu_stall;
    mem_req_t          mem_req;
    logic [DATA_W-1:0] mem_rdata;
    logic              mem_ready;

    logic [DATA_W-1:0] shadow_mem [logic [ADDR_W-1:0]];  // Last written value per word
    logic              ref_valid [NUM_LINES];
    logic [ADDR_W-1:0] ref_tag [NUM_LINES];

    logic [ADDR_W-1:0] rd_addrs [$];  // Transfers seen during one request
    logic [ADDR_W-1:0] wr_addrs [$];
    logic [DATA_W-1:0] wr_datas [$];

    int   seed;
    int   checks;
    int   errors;
    logic timed_out;

    dcache_top #(
        .NUM_LINES (NUM_LINES)
    ) dut0 (
        .clk       (clk),
        .reset     (reset),
        .cpu_req   (cpu_req),
        .cpu_rdata (cpu_rdata),
        .cpu_stall (cpu_stall),
        .mem_req   (mem_req),
        .mem_rdata (mem_rdata),
        .mem_ready (mem_ready)
    );

    mem_model mem0 (
        .clk       (clk),
        .reset     (reset),
        .mem_req   (mem_req),
        .mem_rdata (mem_rdata),
        .mem_ready (mem_ready)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Mid-cycle sampling, the transfer completes at the next rising edge
    always @(negedge clk) begin
        if (!reset && mem_ready) begin
            if (mem_req.read) begin
                rd_addrs.push_back(mem_req.addr);
            end
            if (mem_req.write) begin
                wr_addrs.push_back(mem_req.addr);
                wr_datas.push_back(mem_req.wdata);
            end
        end
    end

    function automatic logic [DATA_W-1:0] initial_word(input logic [ADDR_W-1:0] addr);
        return {addr[15:0], addr[31:16]} ^ 32'h3C5A_96E1;
    endfunction

    // Expected read data and hit from the shadow memory and tag table
    function automatic logic [DATA_W-1:0] predict_read(input logic [ADDR_W-1:0] addr,
                                                       output logic hit);
        int idx;
        idx = int'(addr[LINE_SHIFT +: IDX_W]);
        hit = ref_valid[idx] && (ref_tag[idx] == (addr >> (LINE_SHIFT + IDX_W)));
        if (shadow_mem.exists(addr)) begin
            return shadow_mem[addr];
        end
        return initial_word(addr);
    endfunction

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] expected);
        checks++;
        if (got !== expected) begin
            errors++;
            $display("FAILED at %0t ns: %s is %h, expected %h", $time, what, got, expected);
        end
    endtask

    task automatic run_access(input logic wr, input logic [ADDR_W-1:0] addr,
                              input logic [DATA_W-1:0] wdata);
        logic [DATA_W-1:0] exp_data;
        logic [DATA_W-1:0] got_data;
        logic [ADDR_W-1:0] line_base;
        logic              exp_hit;
        int                cycles;
        int                idx;
        int                i;
        if (timed_out) begin
            return;
        end
        exp_data  = predict_read(addr, exp_hit);
        idx       = int'(addr[LINE_SHIFT +: IDX_W]);
        line_base = (addr >> LINE_SHIFT) << LINE_SHIFT;
        rd_addrs.delete();
        wr_addrs.delete();
        wr_datas.delete();
        cpu_req.read  = !wr;
        cpu_req.write = wr;
        cpu_req.addr  = addr;
        cpu_req.wdata = wdata;
        cycles = 0;
        @(negedge clk);
        while (cpu_stall && cycles < TIMEOUT) begin
            cycles++;
            @(negedge clk);
        end
        if (cpu_stall) begin
            $display("Timeout: the cache never completed the request to address %h", addr);
            timed_out = 1'b1;
        end else begin
            got_data = cpu_rdata;
            @(posedge clk);
            #1;
            cpu_req = '0;
            if (wr) begin
                check_value("memory write count", wr_addrs.size(), 1);
                check_value("memory read count", rd_addrs.size(), 0);
                if (wr_addrs.size() == 1) begin
                    check_value("write address", wr_addrs[0], addr);
                    check_value("write data", wr_datas[0], wdata);
                end
                shadow_mem[addr] = wdata;  // Write-through keeps memory current
            end else begin
                check_value("memory read count", rd_addrs.size(),
                            exp_hit ? 0 : WORDS_PER_LINE);
                check_value("memory write count", wr_addrs.size(), 0);
                if (exp_hit) begin
                    check_value("hit stall cycles", cycles, 0);  // Hit answers in one cycle
                end
                for (i = 0; i < rd_addrs.size(); i++) begin
                    check_value("refill address", rd_addrs[i], line_base + ADDR_W'(4 * i));
                end
                check_value("read data", got_data, exp_data);
                ref_valid[idx] = 1'b1;
                ref_tag[idx]   = addr >> (LINE_SHIFT + IDX_W);
            end
        end
    endtask

    task automatic report_test(input string name, input int errors_before);
        $display("Test %s done, %0d mismatches", name, errors - errors_before);
    endtask

    initial begin
        int                mark;
        int                n;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] data;
        logic              wr;
        seed      = 12286;
        checks    = 0;
        errors    = 0;
        timed_out = 1'b0;
        reset     = 1'b1;
        cpu_req   = '0;
        for (n = 0; n < NUM_LINES; n++) begin
            ref_valid[n] = 1'b0;
            ref_tag[n]   = '0;
        end
        repeat (16) @(posedge clk);
        #1;
        reset = 1'b0;

        mark = errors;
        run_access(1'b0, 32'h0000_0100, '0);  // Cold miss
        report_test("read miss refill", mark);

        mark = errors;
        for (n = 0; n < WORDS_PER_LINE; n++) begin
            run_access(1'b0, 32'h0000_0100 + ADDR_W'(4 * n), '0);
        end
        report_test("read hits in line", mark);

        mark = errors;
        run_access(1'b1, 32'h0000_0108, 32'hDEAD_BEEF);
        run_access(1'b0, 32'h0000_0108, '0);
        report_test("write hit", mark);

        mark = errors;
        run_access(1'b1, 32'h0000_2040, 32'h1234_5678);  // Line 2 still invalid
        run_access(1'b0, 32'h0000_2040, '0);
        report_test("write miss", mark);

        mark = errors;
        run_access(1'b0, 32'h0000_0500, '0);  // Same index as 0x100
        run_access(1'b0, 32'h0000_0100, '0);
        report_test("eviction", mark);

        mark = errors;
        for (n = 0; n < 400; n++) begin
            data = $random(seed);
            wr   = data[0];
            addr = $random(seed) & 32'h0000_0FFC;  // 4 KB window over a 1 KB cache
            data = $random(seed);
            run_access(wr, addr, data);
        end
        report_test("random traffic", mark);

        $display("Checks: %0d, mismatches: %0d", checks, errors);
        if (errors == 0 && !timed_out) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- tb/dcache_sva.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_sva (
    input  wire logic                   clk,
    input  wire logic                   reset,
    input  wire logic                   cpu_write,
    input  wire logic                   cpu_stall,
    input  wire dcache_pkg::mem_req_t   mem_req,
    input  wire logic                   mem_ready,
    input  wire logic                   refill_line_done,
    input  wire logic                   in_write_mem
);

    import dcache_pkg::*;

    a_single_op: assert property (@(posedge clk) disable iff (reset)
        !(mem_req.read && mem_req.write))
        else $error("memory read and write requested together");

    // Request must hold while memory withholds ready
    a_req_stable: assert property (@(posedge clk) disable iff (reset)
        (mem_req.read || mem_req.write) && !mem_ready |=> $stable(mem_req))
        else $error("memory request changed before mem_ready");

    a_refill_step: assert property (@(posedge clk) disable iff (reset)
        mem_req.read && mem_ready && !refill_line_done
        |=> mem_req.read && (mem_req.addr == $past(mem_req.addr) + ADDR_W'(4)))
        else $error("refill address did not advance by one word");

    // A CPU write completes only in the cycle memory accepts it
    a_write_stall: assert property (@(posedge clk) disable iff (reset)
        cpu_write && !cpu_stall |-> in_write_mem && mem_req.write && mem_ready)
        else $error("CPU released before memory accepted the write");

endmodule

bind cache_controller dcache_sva sva0 (
    .clk              (clk),
    .reset            (reset),
    .cpu_write        (cpu_req.write),
    .cpu_stall        (cpu_stall),
    .mem_req          (mem_req),
    .mem_ready        (mem_ready),
    .refill_line_done (refill_line_done),
    .in_write_mem     (state_q == WRITE_MEM)
);

`default_nettype wire

//--- tb/mem_model.sv
`timescale 1ns/1ps
`default_nettype none

module mem_model (
    input  wire logic                           clk,
    input  wire logic                           reset,
    input  wire dcache_pkg::mem_req_t           mem_req,
    output logic [dcache_pkg::DATA_W-1:0]       mem_rdata,
    output logic                                mem_ready
);

    import dcache_pkg::*;

    logic [DATA_W-1:0] mem_q [logic [ADDR_W-1:0]];  // Only written words are stored
    int                seed;
    int                delay;
    logic              armed;  // Delay already drawn for the current request

    // Untouched words follow a pattern over the full address
    function automatic logic [DATA_W-1:0] initial_word(input logic [ADDR_W-1:0] addr);
        return {addr[15:0], addr[31:16]} ^ 32'h3C5A_96E1;
    endfunction

    function automatic logic [DATA_W-1:0] read_word(input logic [ADDR_W-1:0] addr);
        if (mem_q.exists(addr)) begin
            return mem_q[addr];
        end
        return initial_word(addr);
    endfunction

    initial begin
        seed      = 12286;
        delay     = 0;
        armed     = 1'b0;
        mem_ready = 1'b0;
        mem_rdata = '0;
        forever begin
            @(posedge clk);
            #1;
            if (mem_ready) begin
                mem_ready = 1'b0;  // Transfer finished on this edge
                armed     = 1'b0;
            end
            if (reset) begin
                armed = 1'b0;
            end else if (mem_req.read || mem_req.write) begin
                if (!armed) begin
                    delay = $unsigned($random(seed)) % 4;  // 0 to 3 wait cycles
                    armed = 1'b1;
                end
                if (delay == 0) begin
                    mem_ready = 1'b1;
                    if (mem_req.write) begin
                        mem_q[mem_req.addr] = mem_req.wdata;
                    end else begin
                        mem_rdata = read_word(mem_req.addr);
                    end
                end else begin
                    delay = delay - 1;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- rtl/dcache_top.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_top #(
    parameter int NUM_LINES = 32
) (
    input  wire logic                           clk,
    input  wire logic                           reset,
    // CPU port
    input  wire dcache_pkg::cpu_req_t           cpu_req,
    output logic [dcache_pkg::DATA_W-1:0]       cpu_rdata,
    output logic                                cpu_stall,
    // Memory port
    output dcache_pkg::mem_req_t                mem_req,
    input  wire logic [dcache_pkg::DATA_W-1:0]  mem_rdata,
    input  wire logic                           mem_ready
);

    import dcache_pkg::*;

    localparam int IDX_W  = $clog2(NUM_LINES);
    localparam int TAG_W  = ADDR_W - IDX_W - WORD_OFF_W - BYTE_OFF_W;
    localparam int LINE_W = TAG_W + IDX_W;
    localparam int DIDX_W = IDX_W + WORD_OFF_W;

    typedef logic [TAG_W-1:0]  tag_t;
    typedef logic [DATA_W-1:0] word_t;

    tag_t              tag_rd;
    tag_t              tag_wr;
    logic              tag_wr_en;
    word_t             data_rd;
    word_t             data_wr;
    logic              data_wr_en;
    logic [DIDX_W-1:0] data_wr_idx;

    logic                  refill_start;
    logic                  refill_active;
    logic [ADDR_W-1:0]     refill_addr;
    logic [WORD_OFF_W-1:0] refill_word_idx;
    logic                  refill_word_done;
    logic                  refill_line_done;

    cache_controller #(
        .NUM_LINES (NUM_LINES)
    ) u_controller (
        .clk              (clk),
        .reset            (reset),
        .cpu_req          (cpu_req),
        .cpu_rdata        (cpu_rdata),
        .cpu_stall        (cpu_stall),
        .mem_req          (mem_req),
        .mem_rdata        (mem_rdata),
        .mem_ready        (mem_ready),
        .tag_rd           (tag_rd),
        .tag_wr_en        (tag_wr_en),
        .tag_wr           (tag_wr),
        .data_rd          (data_rd),
        .data_wr_en       (data_wr_en),
        .data_wr_idx      (data_wr_idx),
        .data_wr          (data_wr),
        .refill_start     (refill_start),
        .refill_active    (refill_active),
        .refill_addr      (refill_addr),
        .refill_word_idx  (refill_word_idx),
        .refill_word_done (refill_word_done),
        .refill_line_done (refill_line_done)
    );

    // Line base is the tag and index of the held request
    line_refill #(
        .NUM_LINES (NUM_LINES)
    ) u_refill (
        .clk         (clk),
        .reset       (reset),
        .start       (refill_start),
        .line_base   (cpu_req.addr[ADDR_W-1 -: LINE_W]),
        .mem_ready   (mem_ready),
        .active      (refill_active),
        .refill_addr (refill_addr),
        .word_idx    (refill_word_idx),
        .word_done   (refill_word_done),
        .line_done   (refill_line_done)
    );

    cache_array #(
        .entry_t (tag_t),
        .DEPTH   (NUM_LINES)
    ) tag_array (
        .clk     (clk),
        .wr_en   (tag_wr_en),
        .wr_addr (cpu_req.addr[BYTE_OFF_W + WORD_OFF_W +: IDX_W]),
        .wr_data (tag_wr),
        .rd_addr (cpu_req.addr[BYTE_OFF_W + WORD_OFF_W +: IDX_W]),
        .rd_data (tag_rd)
    );

    // Index and word select form the data address
    cache_array #(
        .entry_t (word_t),
        .DEPTH   (NUM_LINES * WORDS_PER_LINE)
    ) data_array (
        .clk     (clk),
        .wr_en   (data_wr_en),
        .wr_addr (data_wr_idx),
        .wr_data (data_wr),
        .rd_addr (cpu_req.addr[BYTE_OFF_W +: DIDX_W]),
        .rd_data (data_rd)
    );

endmodule

`default_nettype wire

//--- rtl/cache_controller.sv
`timescale 1ns/1ps
`default_nettype none

module cache_controller #(
    parameter int  NUM_LINES = 32,
    localparam int IDX_W     = $clog2(NUM_LINES),
    localparam int TAG_W     = dcache_pkg::ADDR_W - IDX_W
                             - dcache_pkg::WORD_OFF_W - dcache_pkg::BYTE_OFF_W,
    localparam int DIDX_W    = IDX_W + dcache_pkg::WORD_OFF_W
) (
    input  wire logic                               clk,
    input  wire logic                               reset,
    // CPU side
    input  wire dcache_pkg::cpu_req_t               cpu_req,
    output logic [dcache_pkg::DATA_W-1:0]           cpu_rdata,
    output logic                                    cpu_stall,
    // Memory side
    output dcache_pkg::mem_req_t                    mem_req,
    input  wire logic [dcache_pkg::DATA_W-1:0]      mem_rdata,
    input  wire logic                               mem_ready,
    // Tag array
    input  wire logic [TAG_W-1:0]                   tag_rd,
    output logic                                    tag_wr_en,
    output logic [TAG_W-1:0]                        tag_wr,
    // Data array
    input  wire logic [dcache_pkg::DATA_W-1:0]      data_rd,
    output logic                                    data_wr_en,
    output logic [DIDX_W-1:0]                       data_wr_idx,
    output logic [dcache_pkg::DATA_W-1:0]           data_wr,
    // Refill unit
    output logic                                    refill_start,
    input  wire logic                               refill_active,
    input  wire logic [dcache_pkg::ADDR_W-1:0]      refill_addr,
    input  wire logic [dcache_pkg::WORD_OFF_W-1:0]  refill_word_idx,
    input  wire logic                               refill_word_done,
    input  wire logic                               refill_line_done
);

    import dcache_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        REFILL,
        WRITE_MEM
    } state_t;

    state_t state_q;
    state_t state_d;

    logic [NUM_LINES-1:0] valid_q;
    logic [DATA_W-1:0]    wdata_q;  // Write-through data

    logic [TAG_W-1:0]      req_tag;
    logic [IDX_W-1:0]      req_index;
    logic [WORD_OFF_W-1:0] req_word;
    logic                  hit;

    // Address split
    assign req_tag   = cpu_req.addr[ADDR_W-1 -: TAG_W];
    assign req_index = cpu_req.addr[BYTE_OFF_W + WORD_OFF_W +: IDX_W];
    assign req_word  = cpu_req.addr[BYTE_OFF_W +: WORD_OFF_W];

    assign hit = valid_q[req_index] && (tag_rd == req_tag);

    always_ff @(posedge clk) begin
        if (reset) begin
            state_q <= IDLE;
            valid_q <= '0;
        end else begin
            state_q <= state_d;
            if (tag_wr_en) begin
                valid_q[req_index] <= 1'b1;  // Line usable from next cycle
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == IDLE && cpu_req.write) begin
            wdata_q <= cpu_req.wdata;
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (cpu_req.read && !hit) begin
                    state_d = REFILL;
                end else if (cpu_req.write) begin
                    state_d = WRITE_MEM;
                end
            end
            REFILL: begin
                if (refill_line_done) begin
                    state_d = IDLE;  // Held read looks up again
                end
            end
            WRITE_MEM: begin
                if (mem_ready) begin
                    state_d = IDLE;
                end
            end
            default: state_d = IDLE;
        endcase
    end

    // Stall and memory request
    always_comb begin
        mem_req   = '0;
        cpu_stall = 1'b0;
        case (state_q)
            IDLE: begin
                cpu_stall = (cpu_req.read && !hit) || cpu_req.write;
            end
            REFILL: begin
                cpu_stall    = 1'b1;
                mem_req.read = refill_active;
                mem_req.addr = refill_addr;
            end
            WRITE_MEM: begin
                cpu_stall     = !mem_ready;  // Released when memory accepts
                mem_req.write = 1'b1;
                mem_req.addr  = cpu_req.addr;
                mem_req.wdata = wdata_q;
            end
            default: cpu_stall = 1'b1;
        endcase
    end

    assign refill_start = (state_q == IDLE) && cpu_req.read && !hit;

    // Tag update on the last refill word
    assign tag_wr_en = (state_q == REFILL) && refill_line_done;
    assign tag_wr    = req_tag;

    // Data port shared by refill and write hit
    always_comb begin
        if (state_q == REFILL) begin
            data_wr_en  = refill_word_done;
            data_wr_idx = {req_index, refill_word_idx};
            data_wr     = mem_rdata;
        end else begin
            data_wr_en  = (state_q == WRITE_MEM) && mem_ready && hit;
            data_wr_idx = {req_index, req_word};
            data_wr     = wdata_q;
        end
    end

    assign cpu_rdata = data_rd;

endmodule

`default_nettype wire

//--- rtl/line_refill.sv
`timescale 1ns/1ps
`default_nettype none

module line_refill #(
    parameter int  NUM_LINES = 32,
    localparam int IDX_W     = $clog2(NUM_LINES),
    localparam int TAG_W     = dcache_pkg::ADDR_W - IDX_W
                             - dcache_pkg::WORD_OFF_W - dcache_pkg::BYTE_OFF_W,
    localparam int LINE_W    = TAG_W + IDX_W
) (
    input  wire logic                               clk,
    input  wire logic                               reset,
    input  wire logic                               start,
    input  wire logic [LINE_W-1:0]                  line_base,
    input  wire logic                               mem_ready,
    output logic                                    active,
    output logic [dcache_pkg::ADDR_W-1:0]           refill_addr,
    output logic [dcache_pkg::WORD_OFF_W-1:0]       word_idx,
    output logic                                    word_done,
    output logic                                    line_done
);

    import dcache_pkg::*;

    localparam logic [WORD_OFF_W-1:0] LAST_WORD = WORD_OFF_W'(WORDS_PER_LINE - 1);

    logic [LINE_W-1:0] base_q;  // Tag and index of the line being filled
    logic              launch;

    assign launch = start && !active;

    // Word counter, wraps back to zero after the last word
    always_ff @(posedge clk) begin
        if (reset) begin
            active   <= 1'b0;
            word_idx <= '0;
        end else if (launch) begin
            active   <= 1'b1;
            word_idx <= '0;
        end else if (word_done) begin
            word_idx <= word_idx + 1'b1;
            if (line_done) begin
                active <= 1'b0;  // Line complete
            end
        end
    end

    always_ff @(posedge clk) begin
        if (launch) begin
            base_q <= line_base;
        end
    end

    // Word accepted by memory in this cycle
    assign word_done = active && mem_ready;
    assign line_done = word_done && (word_idx == LAST_WORD);

    // Line base plus 4 times the word index
    assign refill_addr = {base_q, word_idx, {BYTE_OFF_W{1'b0}}};

endmodule

`default_nettype wire

//--- rtl/cache_array.sv
`timescale 1ns/1ps
`default_nettype none

module cache_array #(
    parameter type     entry_t = logic [31:0],
    parameter int      DEPTH   = 32,
    localparam int     AW      = $clog2(DEPTH)
) (
    input  wire logic          clk,
    input  wire logic          wr_en,
    input  wire logic [AW-1:0] wr_addr,
    input  wire entry_t        wr_data,
    input  wire logic [AW-1:0] rd_addr,
    output entry_t             rd_data
);

    entry_t mem_q [DEPTH];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem_q[wr_addr] <= wr_data;
        end
    end

    // Asynchronous read, lookup completes in the request cycle
    assign rd_data = mem_q[rd_addr];

endmodule

`default_nettype wire

//--- rtl/dcache_pkg.sv
`default_nettype none

package dcache_pkg;

    // Bus widths
    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;

    // Line geometry, 8 words of 4 bytes
    localparam int WORDS_PER_LINE = 8;
    localparam int WORD_OFF_W     = 3;  // Word select within a line
    localparam int BYTE_OFF_W     = 2;  // Byte select within a word

    // CPU request, held by the core while cpu_stall is high
    typedef struct packed {
        logic              read;
        logic              write;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] wdata;
    } cpu_req_t;

    // Memory request, held until mem_ready
    typedef struct packed {
        logic              read;
        logic              write;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] wdata;
    } mem_req_t;

endpackage

`default_nettype wire
